/* list.f */
source/exec_pkg.sv
source/alu_control.sv
source/alu_adder.sv
source/alu_shifter.sv
source/alu_core.sv
source/exec_stage.sv
dv/exec_stage_asserts.sv
dv/exec_stage_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = exec_stage_tb
FILELIST = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "=== PASS ===" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/exec_stage_tb.sv */
module exec_stage_tb import exec_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_ITEMS   = 4000;
	localparam int MAX_CYCLES  = 40000;
	localparam int DRAIN_LIMIT = 100;

	typedef struct {
		instr_class_t cls;
		funct3_t      f3;
		funct7_t      f7;
		xlen_t        a;
		xlen_t        b;
		xlen_t        res;
		logic         tkn;
		logic         ill;
	} expect_t;

	logic         clk;
	logic         rst;
	logic         in_valid;
	logic         in_ready;
	instr_class_t instr_class;
	funct3_t      funct3;
	funct7_t      funct7;
	xlen_t        rs1_val;
	xlen_t        rs2_val;
	xlen_t        imm;
	logic         out_valid;
	logic         out_ready;
	xlen_t        result;
	logic         taken;
	logic         illegal;

	logic [31:0]  lfsr_state;
	expect_t      pending [$]; // Accepted, not yet delivered
	expect_t      front;
	int           errors;
	int           checks;
	int           timeouts;
	logic         was_held;
	xlen_t        held_result;
	logic         held_taken;
	logic         held_illegal;

	exec_stage uut (
		.clk         (clk),
		.rst         (rst),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.instr_class (instr_class),
		.funct3      (funct3),
		.funct7      (funct7),
		.rs1_val     (rs1_val),
		.rs2_val     (rs2_val),
		.imm         (imm),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.result      (result),
		.taken       (taken),
		.illegal     (illegal)
	);

	bind exec_stage exec_stage_asserts u_asserts (
		.clk       (clk),
		.rst       (rst),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.result    (result),
		.taken     (taken),
		.illegal   (illegal)
	);

	// x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [63:0] take_bits(input int n);
		logic [63:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			v          = {v[62:0], fb};
		end
		return v;
	endfunction

	function automatic xlen_t pick_operand();
		logic [2:0] kind;
		kind = 3'(take_bits(3));
		case (kind)
			3'd0:    return '0;
			3'd1:    return '1;
			3'd2:    return {1'b1, 63'd0};           // Most negative
			3'd3:    return {1'b0, {63{1'b1}}};      // Most positive
			3'd4:    return {32'd0, 1'b1, 31'd0};    // Word sign bit
			3'd5:    return xlen_t'(take_bits(6));   // Small value
			default: return take_bits(64);
		endcase
	endfunction

	task automatic load_item();
		logic [3:0]  sel;
		logic [11:0] t12;
		in_valid = 1'b1;
		sel = 4'(take_bits(4));
		instr_class = instr_class_t'(sel < 4'd14 ? 3'(sel % 4'd6) : 3'(sel - 4'd8));
		funct3 = funct3_t'(take_bits(3));
		sel = 4'(take_bits(4));
		if (sel < 4'd7)
			funct7 = F7_BASE;
		else if (sel < 4'd12)
			funct7 = F7_ALT;
		else if (sel < 4'd14)
			funct7 = (sel[0] ? F7_ALT : F7_BASE) | 7'd1; // Shamt bit 5 set
		else
			funct7 = funct7_t'(take_bits(7));
		rs1_val = pick_operand();
		if (take_bits(2) == 0)
			rs2_val = rs1_val; // Equal operands
		else
			rs2_val = pick_operand();
		t12 = 12'(take_bits(12));
		if ((instr_class == class_op_imm || instr_class == class_op_imm_32) &&
			(funct3 == F3_SLL || funct3 == F3_SR))
			t12[11:5] = funct7; // Shift immediates carry funct7
		imm = {{52{t12[11]}}, t12};
	endtask

	function automatic expect_t predict(input instr_class_t cls, input funct3_t f3,
		input funct7_t f7, input xlen_t a, input xlen_t r2, input xlen_t im);
		expect_t e;
		xlen_t   b;
		xlen_t   r;
		word_t   aw;
		word_t   rw;
		logic    is_word;
		logic    alt;
		logic    ok;
		int      sh;
		is_word = (cls == class_op_32) || (cls == class_op_imm_32);
		b       = (cls == class_op || cls == class_op_32 || cls == class_branch) ? r2 : im;
		alt     = (f7 == F7_ALT);
		ok      = 1'b1;
		case (cls)
			class_op, class_op_32: begin
				ok = (f7 == F7_BASE) || (alt && (f3 == F3_ADD || f3 == F3_SR));
				if (cls == class_op_32 && !(f3 == F3_ADD || f3 == F3_SLL || f3 == F3_SR))
					ok = 1'b0;
			end
			class_op_imm: begin
				if (f3 == F3_SLL)
					ok = ((f7 & 7'h7e) == F7_BASE);
				if (f3 == F3_SR)
					ok = ((f7 & 7'h7e) == F7_BASE) || ((f7 & 7'h7e) == F7_ALT);
				alt = (f3 == F3_SR) && ((f7 & 7'h7e) == F7_ALT);
			end
			class_op_imm_32: begin
				ok = (f3 == F3_ADD) || (f3 == F3_SLL && f7 == F7_BASE) ||
					(f3 == F3_SR && (f7 == F7_BASE || alt));
				alt = alt && (f3 == F3_SR);
			end
			class_branch: ok = (f3 != 3'd2) && (f3 != 3'd3);
			class_mem:    ok = 1'b1;
			default:      ok = 1'b0;
		endcase
		sh = is_word ? int'(b[4:0]) : int'(b[5:0]);
		aw = a[31:0];
		r  = '0;
		case (f3)
			F3_ADD:  r = alt ? a - b : a + b;
			F3_SLL:  r = a << sh;
			F3_SLT:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
			F3_SLTU: r = (a < b) ? 64'd1 : 64'd0;
			F3_XOR:  r = a ^ b;
			F3_OR:   r = a | b;
			F3_AND:  r = a & b;
			F3_SR: begin
				if (is_word && alt) begin
					rw = word_t'($signed(aw) >>> sh);
					r  = {32'd0, rw};
				end else if (is_word) begin
					rw = aw >> sh;
					r  = {32'd0, rw};
				end else if (alt) begin
					r = $signed(a) >>> sh;
				end else begin
					r = a >> sh;
				end
			end
		endcase
		if (is_word)
			r = {{32{r[31]}}, r[31:0]};
		if (cls == class_mem)
			r = a + b;
		e.tkn = 1'b0;
		if (cls == class_branch) begin
			r = a - b;
			case (f3)
				F3_BEQ:  e.tkn = (a == b);
				F3_BNE:  e.tkn = (a != b);
				F3_BLT:  e.tkn = ($signed(a) < $signed(b));
				F3_BGE:  e.tkn = ($signed(a) >= $signed(b));
				F3_BLTU: e.tkn = (a < b);
				F3_BGEU: e.tkn = (a >= b);
				default: e.tkn = 1'b0;
			endcase
		end
		if (!ok) begin
			r     = '0;
			e.tkn = 1'b0;
		end
		e.cls = cls;
		e.f3  = f3;
		e.f7  = f7;
		e.a   = a;
		e.b   = b;
		e.res = r;
		e.ill = !ok;
		return e;
	endfunction

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Scoreboard, sampled on the rising edge
	always @(posedge clk) begin
		if (!rst) begin
			assert (in_ready === (!out_valid || out_ready)) else begin
				errors++;
				$display("ERROR %0t: in_ready=%b with out_valid=%b out_ready=%b",
					$time, in_ready, out_valid, out_ready);
			end
			assert (pending.size() <= 1 && out_valid === (pending.size() == 1)) else begin
				errors++;
				$display("ERROR %0t: out_valid=%b with %0d results outstanding",
					$time, out_valid, pending.size());
			end
			if (was_held) begin
				assert (out_valid && result === held_result && taken === held_taken &&
					illegal === held_illegal) else begin
					errors++;
					$display("ERROR %0t: held output changed to res=%h tkn=%b ill=%b",
						$time, result, taken, illegal);
				end
			end
			was_held     = out_valid && !out_ready;
			held_result  = result;
			held_taken   = taken;
			held_illegal = illegal;
			if (out_valid && out_ready && pending.size() != 0) begin
				front = pending.pop_front();
				checks++;
				assert (result === front.res && taken === front.tkn &&
					illegal === front.ill) else begin
					errors++;
					$display("ERROR %0t: class=%0d f3=%0d f7=%h a=%h b=%h", $time,
						front.cls, front.f3, front.f7, front.a, front.b);
					$display("  expected res=%h tkn=%b ill=%b, got res=%h tkn=%b ill=%b",
						front.res, front.tkn, front.ill, result, taken, illegal);
				end
			end
			if (in_valid && in_ready)
				pending.push_back(predict(instr_class, funct3, funct7, rs1_val, rs2_val, imm));
		end
	end

	initial begin
		int   sent;
		int   cycles;
		int   drain;
		logic fired;
		lfsr_state  = 32'hf18d9ffe;
		rst         = 1'b1;
		in_valid    = 1'b0;
		instr_class = class_op;
		funct3      = '0;
		funct7      = '0;
		rs1_val     = '0;
		rs2_val     = '0;
		imm         = '0;
		out_ready   = 1'b0;
		errors      = 0;
		checks      = 0;
		timeouts    = 0;
		was_held    = 1'b0;
		sent        = 0;
		cycles      = 0;
		drain       = 0;
		fired       = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		while (sent < NUM_ITEMS && cycles < MAX_CYCLES) begin
			@(negedge clk);
			out_ready = (take_bits(2) != 0); // Ready three times in four
			if (!in_valid || fired) begin
				if (take_bits(2) != 0)
					load_item();
				else
					in_valid = 1'b0; // Idle cycle
			end
			@(posedge clk);
			fired = in_valid && in_ready;
			if (fired)
				sent++;
			cycles++;
		end
		if (sent < NUM_ITEMS) begin
			timeouts++;
			$display("Timed out after %0d cycles with only %0d inputs accepted", cycles, sent);
		end

		@(negedge clk);
		in_valid  = 1'b0;
		out_ready = 1'b1;
		while ((out_valid || pending.size() != 0) && drain < DRAIN_LIMIT) begin
			@(negedge clk);
			drain++;
		end
		if (out_valid || pending.size() != 0) begin
			timeouts++;
			$display("Timed out waiting for the last results to leave the output register");
		end
		repeat (2) @(negedge clk);

		$display("Checked %0d results: %0d errors, %0d timeouts", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* dv/exec_stage_asserts.sv */
module exec_stage_asserts import exec_pkg::*; (
	input logic  clk,
	input logic  rst,
	input logic  in_ready,
	input logic  out_valid,
	input logic  out_ready,
	input xlen_t result,
	input logic  taken,
	input logic  illegal
);

	timeunit 1ns;
	timeprecision 1ps;

	// Output register starts empty
	valid_after_reset: assert property (
		@(posedge clk) rst |=> !out_valid
	) else $error("out_valid is high in the cycle after reset");

	// Back-pressure freezes the output register
	output_held: assert property (
		@(posedge clk) disable iff (rst)
		(out_valid && !out_ready) |=>
			(out_valid && $stable(result) && $stable(taken) && $stable(illegal))
	) else $error("output changed while held by back-pressure");

	ready_follows_valid: assert property (
		@(posedge clk) disable iff (rst)
		in_ready == (!out_valid || out_ready)
	) else $error("in_ready does not match the output slot state");

endmodule

/* source/exec_stage.sv */
module exec_stage import exec_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         in_valid,
	output logic         in_ready,
	input  instr_class_t instr_class,
	input  funct3_t      funct3,
	input  funct7_t      funct7,
	input  xlen_t        rs1_val,
	input  xlen_t        rs2_val,
	input  xlen_t        imm,
	output logic         out_valid,
	input  logic         out_ready,
	output xlen_t        result,
	output logic         taken,
	output logic         illegal
);

	alu_op_t alu_op;
	logic    word;
	logic    use_imm;
	logic    is_branch;
	logic    illegal_op;
	xlen_t   op_b;
	xlen_t   alu_result;
	logic    alu_taken;
	logic    accept;

	alu_control u_alu_control (
		.instr_class (instr_class),
		.funct3      (funct3),
		.funct7      (funct7),
		.alu_op      (alu_op),
		.word        (word),
		.use_imm     (use_imm),
		.is_branch   (is_branch),
		.illegal_op  (illegal_op)
	);

	assign op_b = use_imm ? imm : rs2_val;

	alu_core u_alu_core (
		.op_a      (rs1_val),
		.op_b      (op_b),
		.alu_op    (alu_op),
		.word      (word),
		.is_branch (is_branch),
		.funct3    (funct3),
		.result    (alu_result),
		.taken     (alu_taken)
	);

	// Output slot frees up in the same cycle it drains
	assign in_ready = ~out_valid | out_ready;
	assign accept   = in_valid & in_ready;

	always_ff @(posedge clk) begin
		if (rst)
			out_valid <= 1'b0;
		else if (in_ready)
			out_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			result  <= illegal_op ? '0 : alu_result; // Illegal reads as zero
			taken   <= alu_taken & ~illegal_op;
			illegal <= illegal_op;
		end
	end

endmodule

/* source/alu_core.sv */
module alu_core import exec_pkg::*; (
	input  xlen_t   op_a,
	input  xlen_t   op_b,
	input  alu_op_t alu_op,
	input  logic    word,
	input  logic    is_branch,
	input  funct3_t funct3,
	output xlen_t   result,
	output logic    taken
);

	logic   sub;
	xlen_t  sum;
	logic   carry;
	logic   overflow;
	logic   zero;
	logic   lt_s;
	logic   lt_u;
	shamt_t shamt;
	logic   shift_right;
	logic   shift_arith;
	xlen_t  shift_out;
	xlen_t  raw;
	word_t  raw_word;

	// Compares and branches all run through the subtractor
	assign sub = is_branch || (alu_op == alu_sub) || (alu_op == alu_slt) ||
		(alu_op == alu_sltu);

	alu_adder u_adder (
		.in_a     (op_a),
		.in_b     (op_b),
		.sub      (sub),
		.sum      (sum),
		.carry    (carry),
		.overflow (overflow),
		.zero     (zero)
	);

	assign lt_s = sum[XLEN-1] ^ overflow;
	assign lt_u = ~carry; // Borrow out

	assign shamt       = op_b[SHAMT_W-1:0];
	assign shift_right = (alu_op == alu_srl) || (alu_op == alu_sra);
	assign shift_arith = (alu_op == alu_sra);

	alu_shifter u_shifter (
		.din   (op_a),
		.shamt (shamt),
		.right (shift_right),
		.arith (shift_arith),
		.word  (word),
		.dout  (shift_out)
	);

	always_comb begin
		case (alu_op)
			alu_and:  raw = op_a & op_b;
			alu_or:   raw = op_a | op_b;
			alu_xor:  raw = op_a ^ op_b;
			alu_slt:  raw = {{(XLEN-1){1'b0}}, lt_s};
			alu_sltu: raw = {{(XLEN-1){1'b0}}, lt_u};
			alu_sll, alu_srl, alu_sra: raw = shift_out;
			default:  raw = sum; // add, sub
		endcase
	end

	assign raw_word = raw[WLEN-1:0];
	assign result   = word ? {{(XLEN-WLEN){raw_word[WLEN-1]}}, raw_word} : raw;

	always_comb begin
		taken = 1'b0;
		if (is_branch) begin
			case (funct3)
				F3_BEQ:  taken = zero;
				F3_BNE:  taken = ~zero;
				F3_BLT:  taken = lt_s;
				F3_BGE:  taken = ~lt_s;
				F3_BLTU: taken = lt_u;
				F3_BGEU: taken = ~lt_u;
				default: taken = 1'b0;
			endcase
		end
	end

endmodule

/* source/alu_shifter.sv */
module alu_shifter import exec_pkg::*; (
	input  xlen_t  din,
	input  shamt_t shamt,
	input  logic   right,
	input  logic   arith,
	input  logic   word,
	output xlen_t  dout
);

	word_t  low_word;
	xlen_t  src;
	shamt_t amt;
	logic   fill;
	xlen_t  stage [0:SHAMT_W];

	function automatic xlen_t bit_rev(input xlen_t v);
		xlen_t r;
		r = '0;
		for (int i = 0; i < XLEN; i++) begin
			r[i] = v[XLEN-1-i];
		end
		return r;
	endfunction

	assign low_word = din[WLEN-1:0];

	// Word mode works on the low word, sign extended only for sra
	assign src = word ? {{(XLEN-WLEN){arith & low_word[WLEN-1]}}, low_word} : din;
	assign amt = word ? {1'b0, shamt[SHAMT_W-2:0]} : shamt;

	assign fill = right & arith & src[XLEN-1]; // Left shifts fill with zero

	// Left shift is done as a right shift of the reversed operand
	assign stage[0] = right ? src : bit_rev(src);

	for (genvar i = 0; i < SHAMT_W; i++) begin : g_stage
		assign stage[i+1] = amt[i] ? {{(2**i){fill}}, stage[i][XLEN-1:2**i]} : stage[i];
	end

	assign dout = right ? stage[SHAMT_W] : bit_rev(stage[SHAMT_W]);

endmodule

/* source/alu_adder.sv */
module alu_adder import exec_pkg::*; (
	input  xlen_t in_a,
	input  xlen_t in_b,
	input  logic  sub,
	output xlen_t sum,
	output logic  carry,
	output logic  overflow,
	output logic  zero
);

	xlen_t b_eff;

	// Two's complement subtract via inverted operand and carry in
	assign b_eff = sub ? ~in_b : in_b;

	assign {carry, sum} = {1'b0, in_a} + {1'b0, b_eff} + {{XLEN{1'b0}}, sub};

	// Same input signs, different result sign
	assign overflow = (in_a[XLEN-1] == b_eff[XLEN-1]) && (sum[XLEN-1] != in_a[XLEN-1]);

	assign zero = (sum == '0);

endmodule

/* source/alu_control.sv */
module alu_control import exec_pkg::*; (
	input  instr_class_t instr_class,
	input  funct3_t      funct3,
	input  funct7_t      funct7,
	output alu_op_t      alu_op,
	output logic         word,
	output logic         use_imm,
	output logic         is_branch,
	output logic         illegal_op
);

	logic    f7_base;     // Whole funct7 is zero
	logic    f7_alt;      // Whole funct7 selects alternate op
	logic    f7_sh_base;  // Same, ignoring shamt bit 5
	logic    f7_sh_alt;
	logic    alt_legal;   // funct3 accepts F7_ALT
	logic    word_f3;     // funct3 exists in word form
	logic    imm_alt;
	alu_op_t reg_op;
	alu_op_t imm_op;

	function automatic alu_op_t decode_f3(input funct3_t f3, input logic alt);
		alu_op_t op;
		op = alu_and;
		case (f3)
			F3_ADD:  op = alt ? alu_sub : alu_add;
			F3_SLL:  op = alu_sll;
			F3_SLT:  op = alu_slt;
			F3_SLTU: op = alu_sltu;
			F3_XOR:  op = alu_xor;
			F3_SR:   op = alt ? alu_sra : alu_srl;
			F3_OR:   op = alu_or;
			F3_AND:  op = alu_and;
		endcase
		return op;
	endfunction

	assign f7_base    = (funct7 == F7_BASE);
	assign f7_alt     = (funct7 == F7_ALT);
	assign f7_sh_base = ({funct7[FUNCT7_W-1:1], 1'b0} == F7_BASE);
	assign f7_sh_alt  = ({funct7[FUNCT7_W-1:1], 1'b0} == F7_ALT);
	assign alt_legal  = (funct3 == F3_ADD) || (funct3 == F3_SR);
	assign word_f3    = (funct3 == F3_ADD) || (funct3 == F3_SLL) || (funct3 == F3_SR);
	assign imm_alt    = (funct3 == F3_SR) && f7_sh_alt; // No subi, only srai

	assign reg_op = decode_f3(funct3, f7_alt);
	assign imm_op = decode_f3(funct3, imm_alt);

	always_comb begin
		alu_op     = alu_add;
		word       = 1'b0;
		use_imm    = 1'b0;
		is_branch  = 1'b0;
		illegal_op = 1'b0;
		case (instr_class)
			class_op, class_op_32: begin
				word       = (instr_class == class_op_32);
				alu_op     = reg_op;
				illegal_op = !(f7_base || (f7_alt && alt_legal));
				if (word && !word_f3)
					illegal_op = 1'b1; // No slt/logic in word form
			end
			class_op_imm: begin
				use_imm = 1'b1;
				alu_op  = imm_op;
				if (funct3 == F3_SLL)
					illegal_op = !f7_sh_base;
				else if (funct3 == F3_SR)
					illegal_op = !(f7_sh_base || f7_sh_alt);
			end
			class_op_imm_32: begin
				word    = 1'b1;
				use_imm = 1'b1;
				alu_op  = imm_op;
				// addiw carries immediate bits in funct7
				case (funct3)
					F3_ADD:  illegal_op = 1'b0;
					F3_SLL:  illegal_op = !f7_base;
					F3_SR:   illegal_op = !(f7_base || f7_alt);
					default: illegal_op = 1'b1;
				endcase
			end
			class_branch: begin
				alu_op     = alu_sub;
				is_branch  = 1'b1;
				illegal_op = (funct3[2:1] == 2'b01); // funct3 2 and 3 unused
			end
			class_mem: begin
				alu_op  = alu_add;
				use_imm = 1'b1; // Base plus offset
			end
			default: illegal_op = 1'b1;
		endcase
	end

endmodule

/* source/exec_pkg.sv */
package exec_pkg;

	localparam int XLEN     = 64;
	localparam int WLEN     = 32;
	localparam int SHAMT_W  = 6;
	localparam int FUNCT3_W = 3;
	localparam int FUNCT7_W = 7;

	typedef logic [XLEN-1:0]     xlen_t;
	typedef logic [WLEN-1:0]     word_t;
	typedef logic [SHAMT_W-1:0]  shamt_t;
	typedef logic [FUNCT3_W-1:0] funct3_t;
	typedef logic [FUNCT7_W-1:0] funct7_t;

	typedef enum logic [2:0] {
		class_op        = 3'd0, // R-type
		class_op_imm    = 3'd1, // I-type arithmetic
		class_op_32     = 3'd2, // R-type word
		class_op_imm_32 = 3'd3, // I-type word
		class_branch    = 3'd4, // Branch compare
		class_mem       = 3'd5  // Load/store address
	} instr_class_t;

	typedef enum logic [3:0] {
		alu_and  = 4'd0,
		alu_or   = 4'd1,
		alu_xor  = 4'd2,
		alu_add  = 4'd3,
		alu_sub  = 4'd4,
		alu_slt  = 4'd5,
		alu_sltu = 4'd6,
		alu_sll  = 4'd7,
		alu_srl  = 4'd8,
		alu_sra  = 4'd9
	} alu_op_t;

	localparam funct7_t F7_BASE = 7'b000_0000;
	localparam funct7_t F7_ALT  = 7'b010_0000; // sub, sra

	localparam funct3_t F3_ADD  = 3'b000;
	localparam funct3_t F3_SLL  = 3'b001;
	localparam funct3_t F3_SLT  = 3'b010;
	localparam funct3_t F3_SLTU = 3'b011;
	localparam funct3_t F3_XOR  = 3'b100;
	localparam funct3_t F3_SR   = 3'b101; // srl and sra
	localparam funct3_t F3_OR   = 3'b110;
	localparam funct3_t F3_AND  = 3'b111;

	// Branch compares
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

endpackage
